//--- rtl/dma_wr_pkg.sv
/* widths, field types and bus structs of the DMA write engine
   plus the state encoding of the beat unroll FSM */
package dma_wr_pkg;

   localparam int LTAG_W      = 4;
   localparam int NUM_LTAGS   = 16;
   localparam int ETAG_W      = 3;
   localparam int BEAT_W      = 2;
   localparam int MAX_BEATS   = 4;
   localparam int BEAT_BYTES  = 32;
   localparam int BEAT_SHIFT  = $clog2(BEAT_BYTES);
   localparam int DATA_W      = 256;
   localparam int SIZE_W      = 8;
   localparam int EA_W        = 64;
   localparam int RC_W        = 8;
   localparam int PEND_DEPTH  = 16;
   localparam int PEND_AW     = $clog2(PEND_DEPTH);
   // staging memory holds every beat of every local tag
   localparam int STAGE_DEPTH = NUM_LTAGS * MAX_BEATS;

   typedef logic [0:LTAG_W-1] ltag_t;
   typedef logic [0:ETAG_W-1] etag_t;
   typedef logic [0:BEAT_W-1] beat_t;
   typedef logic [0:SIZE_W-1] size_t;
   typedef logic [0:EA_W-1]   ea_t;
   typedef logic [0:RC_W-1]   rc_t;
   typedef logic [0:DATA_W-1] data_t;

   typedef struct packed {etag_t etag; ea_t ea; size_t size;} wr_req_t;

   // per local tag, written at request acceptance
   typedef struct packed {etag_t etag; ea_t ea; size_t size;} cmd_info_t;

   typedef struct packed {etag_t etag; beat_t beat;} wdata_req_t;

   // one entry per fetched beat, waiting for its data
   typedef struct packed {ltag_t ltag; beat_t beat; logic last;} pend_beat_t;

   typedef struct packed {ltag_t ltag; beat_t beat;} host_addr_t;

   // command tag is the local tag
   typedef struct packed {ltag_t tag; ea_t ea; size_t size;} host_cmd_t;

   typedef struct packed {ltag_t tag; rc_t rc;} host_rsp_t;

   typedef struct packed {etag_t etag; rc_t rc;} cpl_t;

   typedef enum logic {
      UNR_IDLE,
      UNR_BEATS
   } unroll_state_t;

endpackage

//--- rtl/tag_pool.sv
`timescale 1ns/100ps
/* local tag pool: free bitmap with lowest-index allocation
   and a free port driven by the completion path */
module tag_pool
  (
   input  logic              i_clk,
   input  logic              i_rst_n,
   output logic              o_alloc_valid,
   input  logic              i_alloc_take,
   output dma_wr_pkg::ltag_t o_alloc_tag,
   input  logic              i_free_valid,
   input  dma_wr_pkg::ltag_t i_free_tag
   );

   // bit set while the tag is free
   logic [0:dma_wr_pkg::NUM_LTAGS-1] free_map;
   logic [0:dma_wr_pkg::NUM_LTAGS-1] free_next;
   dma_wr_pkg::ltag_t                next_tag;

   always_comb
   begin
      free_next = free_map;
      if (i_alloc_take)
      begin
         free_next[o_alloc_tag] = 1'b0;
      end
      if (i_free_valid)
      begin
         free_next[i_free_tag] = 1'b1;
      end
   end

   // scan from the top, last hit is the lowest free index
   always_comb
   begin
      next_tag = '0;
      for (int i = dma_wr_pkg::NUM_LTAGS - 1; i >= 0; i--)
      begin
         if (free_next[i])
         begin
            next_tag = dma_wr_pkg::ltag_t'(i);
         end
      end
   end

   // offer is registered from the next map
   always_ff @(posedge i_clk)
   begin
      if (!i_rst_n)
      begin
         free_map      <= '1;
         o_alloc_valid <= 1'b0;
      end
      else
      begin
         free_map      <= free_next;
         o_alloc_valid <= |free_next;
      end
   end

   always_ff @(posedge i_clk)
   begin
      o_alloc_tag <= next_tag;
   end

   // completion may only return a tag that is out
   a_free_outstanding : assert property (@(posedge i_clk) disable iff (!i_rst_n)
      i_free_valid |-> !free_map[i_free_tag]);

endmodule

//--- rtl/beat_unroll.sv
`timescale 1ns/100ps
/* request intake: tag claim, command info push,
   and one registered data-fetch request per 256-bit beat */
module beat_unroll
  (
   input  logic                   i_clk,
   input  logic                   i_rst_n,
   input  logic                   i_req_valid,
   output logic                   o_req_ready,
   input  dma_wr_pkg::wr_req_t    i_req,
   input  logic                   i_alloc_valid,
   output logic                   o_alloc_take,
   input  dma_wr_pkg::ltag_t      i_alloc_tag,
   output logic                   o_info_we,
   output dma_wr_pkg::ltag_t      o_info_tag,
   output dma_wr_pkg::cmd_info_t  o_info,
   output logic                   o_wdata_req_valid,
   output dma_wr_pkg::wdata_req_t o_wdata_req,
   output logic                   o_pend_push,
   output dma_wr_pkg::pend_beat_t o_pend
   );

   dma_wr_pkg::unroll_state_t state_q;
   dma_wr_pkg::ltag_t         ltag_q;
   dma_wr_pkg::etag_t         etag_q;
   dma_wr_pkg::beat_t         beat_q;
   dma_wr_pkg::beat_t         last_q;
   dma_wr_pkg::size_t         beat_cnt;
   dma_wr_pkg::size_t         beats_m1;
   logic                      accept;
   logic                      last_beat;

   // size rounded up to whole beats
   assign beat_cnt = (i_req.size + dma_wr_pkg::size_t'(dma_wr_pkg::BEAT_BYTES - 1))
                     >> dma_wr_pkg::BEAT_SHIFT;
   assign beats_m1 = beat_cnt - 1'b1;

   assign o_req_ready = (state_q == dma_wr_pkg::UNR_IDLE) && i_alloc_valid;
   assign accept      = i_req_valid && o_req_ready;

   assign o_alloc_take = accept;
   assign o_info_we    = accept;
   assign o_info_tag   = i_alloc_tag;
   assign o_info       = '{etag: i_req.etag, ea: i_req.ea, size: i_req.size};

   always_ff @(posedge i_clk)
   begin
      if (!i_rst_n)
      begin
         state_q <= dma_wr_pkg::UNR_IDLE;
      end
      else
      begin
         case (state_q)
            dma_wr_pkg::UNR_IDLE:
            begin
               if (accept)
               begin
                  state_q <= dma_wr_pkg::UNR_BEATS;
               end
            end
            dma_wr_pkg::UNR_BEATS:
            begin
               if (last_beat)
               begin
                  state_q <= dma_wr_pkg::UNR_IDLE;
               end
            end
            default:
            begin
               state_q <= dma_wr_pkg::UNR_IDLE;
            end
         endcase
      end
   end

   // request fields held for the whole unroll
   always_ff @(posedge i_clk)
   begin
      if (accept)
      begin
         ltag_q <= i_alloc_tag;
         etag_q <= i_req.etag;
         last_q <= beats_m1[dma_wr_pkg::SIZE_W-dma_wr_pkg::BEAT_W:dma_wr_pkg::SIZE_W-1];
         beat_q <= '0;
      end
      else if (state_q == dma_wr_pkg::UNR_BEATS)
      begin
         beat_q <= beat_q + 1'b1;
      end
   end

   assign last_beat = (beat_q == last_q);

   // fetch and pending entry leave together, one beat per cycle
   assign o_wdata_req_valid = (state_q == dma_wr_pkg::UNR_BEATS);
   assign o_wdata_req       = '{etag: etag_q, beat: beat_q};
   assign o_pend_push       = o_wdata_req_valid;
   assign o_pend            = '{ltag: ltag_q, beat: beat_q, last: last_beat};

   a_req_size : assert property (@(posedge i_clk) disable iff (!i_rst_n)
      accept |-> (i_req.size != '0) &&
                 (i_req.size <= dma_wr_pkg::MAX_BEATS * dma_wr_pkg::BEAT_BYTES));

endmodule

//--- rtl/wdata_buffer.sv
`timescale 1ns/100ps
/* pending-beat FIFO, beat staging memory by local tag and beat,
   host read port and the data-done report */
module wdata_buffer
  (
   input  logic                   i_clk,
   input  logic                   i_rst_n,
   input  logic                   i_pend_push,
   input  dma_wr_pkg::pend_beat_t i_pend,
   input  logic                   i_wdata_rsp_valid,
   input  dma_wr_pkg::data_t      i_wdata_rsp_data,
   input  logic                   i_host_rd_valid,
   input  dma_wr_pkg::host_addr_t i_host_rd_addr,
   output dma_wr_pkg::data_t      o_host_rd_data,
   output logic                   o_done_valid,
   output dma_wr_pkg::ltag_t      o_done_tag
   );

   dma_wr_pkg::pend_beat_t          pend_mem [0:dma_wr_pkg::PEND_DEPTH-1];
   logic [0:dma_wr_pkg::PEND_AW-1]  pend_wr_ptr;
   logic [0:dma_wr_pkg::PEND_AW-1]  pend_rd_ptr;
   logic [0:dma_wr_pkg::PEND_AW]    pend_cnt;
   logic                            pend_full;
   logic                            pend_empty;
   dma_wr_pkg::pend_beat_t          pend_head;

   dma_wr_pkg::data_t               stage_mem [0:dma_wr_pkg::STAGE_DEPTH-1];
   logic                            wr_en_q;
   logic                            wr_last_q;
   dma_wr_pkg::host_addr_t          wr_addr_q;
   dma_wr_pkg::data_t               wr_data_q;

   logic                            rd_valid_q;
   dma_wr_pkg::data_t               rd_data_q;

   // depth is a power of two, so full is the count msb
   assign pend_full  = pend_cnt[0];
   assign pend_empty = (pend_cnt == '0);
   assign pend_head  = pend_mem[pend_rd_ptr];

   // data returns in fetch order, each one pops the head
   always_ff @(posedge i_clk)
   begin
      if (!i_rst_n)
      begin
         pend_wr_ptr <= '0;
         pend_rd_ptr <= '0;
         pend_cnt    <= '0;
      end
      else
      begin
         if (i_pend_push)
         begin
            pend_wr_ptr <= pend_wr_ptr + 1'b1;
         end
         if (i_wdata_rsp_valid)
         begin
            pend_rd_ptr <= pend_rd_ptr + 1'b1;
         end
         case ({i_pend_push, i_wdata_rsp_valid})
            2'b10:   pend_cnt <= pend_cnt + 1'b1;
            2'b01:   pend_cnt <= pend_cnt - 1'b1;
            default: pend_cnt <= pend_cnt;
         endcase
      end
   end

   always_ff @(posedge i_clk)
   begin
      if (i_pend_push)
      begin
         pend_mem[pend_wr_ptr] <= i_pend;
      end
   end

   // write stage, one cycle behind the data return
   always_ff @(posedge i_clk)
   begin
      if (!i_rst_n)
      begin
         wr_en_q <= 1'b0;
      end
      else
      begin
         wr_en_q <= i_wdata_rsp_valid;
      end
   end

   always_ff @(posedge i_clk)
   begin
      wr_addr_q <= '{ltag: pend_head.ltag, beat: pend_head.beat};
      wr_last_q <= pend_head.last;
      wr_data_q <= i_wdata_rsp_data;
   end

   always_ff @(posedge i_clk)
   begin
      if (wr_en_q)
      begin
         stage_mem[{wr_addr_q.ltag, wr_addr_q.beat}] <= wr_data_q;
      end
   end

   assign o_done_valid = wr_en_q && wr_last_q;
   assign o_done_tag   = wr_addr_q.ltag;

   // host read: memory read then output register
   always_ff @(posedge i_clk)
   begin
      if (!i_rst_n)
      begin
         rd_valid_q <= 1'b0;
      end
      else
      begin
         rd_valid_q <= i_host_rd_valid;
      end
   end

   always_ff @(posedge i_clk)
   begin
      if (i_host_rd_valid)
      begin
         rd_data_q <= stage_mem[{i_host_rd_addr.ltag, i_host_rd_addr.beat}];
      end
      if (rd_valid_q)
      begin
         o_host_rd_data <= rd_data_q;
      end
   end

   a_pend_no_overflow : assert property (@(posedge i_clk) disable iff (!i_rst_n)
      i_pend_push |-> !pend_full);

   // a data return with nothing fetched is lost
   a_rsp_has_pend : assert property (@(posedge i_clk) disable iff (!i_rst_n)
      i_wdata_rsp_valid |-> !pend_empty);

endmodule

//--- rtl/host_cmd_issue.sv
`timescale 1ns/100ps
/* per-tag command table, ready-command FIFO, host write command
   and the completion path that frees the local tag */
module host_cmd_issue
  (
   input  logic                  i_clk,
   input  logic                  i_rst_n,
   input  logic                  i_info_we,
   input  dma_wr_pkg::ltag_t     i_info_tag,
   input  dma_wr_pkg::cmd_info_t i_info,
   input  logic                  i_done_valid,
   input  dma_wr_pkg::ltag_t     i_done_tag,
   output logic                  o_host_cmd_valid,
   input  logic                  i_host_cmd_ready,
   output dma_wr_pkg::host_cmd_t o_host_cmd,
   input  logic                  i_host_rsp_valid,
   input  dma_wr_pkg::host_rsp_t i_host_rsp,
   output logic                  o_cpl_valid,
   output dma_wr_pkg::cpl_t      o_cpl,
   output logic                  o_free_valid,
   output dma_wr_pkg::ltag_t     o_free_tag
   );

   dma_wr_pkg::cmd_info_t          cmd_tbl [0:dma_wr_pkg::NUM_LTAGS-1];
   dma_wr_pkg::ltag_t              rdy_mem [0:dma_wr_pkg::NUM_LTAGS-1];
   // extra wrap bit tells full from empty
   logic [0:dma_wr_pkg::LTAG_W]    rdy_wr_ptr;
   logic [0:dma_wr_pkg::LTAG_W]    rdy_rd_ptr;
   logic                           cmd_pop;
   dma_wr_pkg::ltag_t              head_tag;

   logic                           rsp_v_q;
   dma_wr_pkg::ltag_t              rsp_tag_q;
   dma_wr_pkg::rc_t                rsp_rc_q;
   dma_wr_pkg::etag_t              rsp_etag_q;

   always_ff @(posedge i_clk)
   begin
      if (i_info_we)
      begin
         cmd_tbl[i_info_tag] <= i_info;
      end
   end

   // ready queue, one slot per local tag so it cannot overflow
   always_ff @(posedge i_clk)
   begin
      if (!i_rst_n)
      begin
         rdy_wr_ptr <= '0;
         rdy_rd_ptr <= '0;
      end
      else
      begin
         if (i_done_valid)
         begin
            rdy_wr_ptr <= rdy_wr_ptr + 1'b1;
         end
         if (cmd_pop)
         begin
            rdy_rd_ptr <= rdy_rd_ptr + 1'b1;
         end
      end
   end

   always_ff @(posedge i_clk)
   begin
      if (i_done_valid)
      begin
         rdy_mem[rdy_wr_ptr[1:dma_wr_pkg::LTAG_W]] <= i_done_tag;
      end
   end

   // command straight from queue head and table
   assign head_tag         = rdy_mem[rdy_rd_ptr[1:dma_wr_pkg::LTAG_W]];
   assign o_host_cmd_valid = (rdy_wr_ptr != rdy_rd_ptr);
   assign o_host_cmd       = '{tag: head_tag,
                               ea: cmd_tbl[head_tag].ea,
                               size: cmd_tbl[head_tag].size};
   assign cmd_pop          = o_host_cmd_valid && i_host_cmd_ready;

   // completion stage 1, engine tag lookup
   always_ff @(posedge i_clk)
   begin
      if (!i_rst_n)
      begin
         rsp_v_q <= 1'b0;
      end
      else
      begin
         rsp_v_q <= i_host_rsp_valid;
      end
   end

   always_ff @(posedge i_clk)
   begin
      rsp_tag_q  <= i_host_rsp.tag;
      rsp_rc_q   <= i_host_rsp.rc;
      rsp_etag_q <= cmd_tbl[i_host_rsp.tag].etag;
   end

   // stage 2, output register
   always_ff @(posedge i_clk)
   begin
      if (!i_rst_n)
      begin
         o_cpl_valid <= 1'b0;
      end
      else
      begin
         o_cpl_valid <= rsp_v_q;
      end
   end

   always_ff @(posedge i_clk)
   begin
      o_cpl      <= '{etag: rsp_etag_q, rc: rsp_rc_q};
      o_free_tag <= rsp_tag_q;
   end

   assign o_free_valid = o_cpl_valid;

   a_cmd_hold : assert property (@(posedge i_clk) disable iff (!i_rst_n)
      o_host_cmd_valid && !i_host_cmd_ready |=> o_host_cmd_valid && $stable(o_host_cmd));

endmodule

//--- rtl/dma_wr_top.sv
`timescale 1ns/100ps
/* DMA write engine top: tag pool, beat unroll,
   write data buffer and host command issue */
module dma_wr_top
  (
   input  logic                   i_clk,
   input  logic                   i_rst_n,
   input  logic                   i_req_valid,
   output logic                   o_req_ready,
   input  dma_wr_pkg::wr_req_t    i_req,
   output logic                   o_wdata_req_valid,
   output dma_wr_pkg::wdata_req_t o_wdata_req,
   input  logic                   i_wdata_rsp_valid,
   input  dma_wr_pkg::data_t      i_wdata_rsp_data,
   output logic                   o_host_cmd_valid,
   input  logic                   i_host_cmd_ready,
   output dma_wr_pkg::host_cmd_t  o_host_cmd,
   input  logic                   i_host_rd_valid,
   input  dma_wr_pkg::host_addr_t i_host_rd_addr,
   output dma_wr_pkg::data_t      o_host_rd_data,
   input  logic                   i_host_rsp_valid,
   input  dma_wr_pkg::host_rsp_t  i_host_rsp,
   output logic                   o_cpl_valid,
   output dma_wr_pkg::cpl_t       o_cpl
   );

   logic                   alloc_valid;
   logic                   alloc_take;
   dma_wr_pkg::ltag_t      alloc_tag;
   logic                   info_we;
   dma_wr_pkg::ltag_t      info_tag;
   dma_wr_pkg::cmd_info_t  info;
   logic                   pend_push;
   dma_wr_pkg::pend_beat_t pend;
   logic                   done_valid;
   dma_wr_pkg::ltag_t      done_tag;
   logic                   free_valid;
   dma_wr_pkg::ltag_t      free_tag;

   tag_pool i_tag_pool
     (.i_clk(i_clk), .i_rst_n(i_rst_n),
      .o_alloc_valid(alloc_valid), .i_alloc_take(alloc_take), .o_alloc_tag(alloc_tag),
      .i_free_valid(free_valid), .i_free_tag(free_tag));

   beat_unroll i_beat_unroll
     (.i_clk(i_clk), .i_rst_n(i_rst_n),
      .i_req_valid(i_req_valid), .o_req_ready(o_req_ready), .i_req(i_req),
      .i_alloc_valid(alloc_valid), .o_alloc_take(alloc_take), .i_alloc_tag(alloc_tag),
      .o_info_we(info_we), .o_info_tag(info_tag), .o_info(info),
      .o_wdata_req_valid(o_wdata_req_valid), .o_wdata_req(o_wdata_req),
      .o_pend_push(pend_push), .o_pend(pend));

   wdata_buffer i_wdata_buffer
     (.i_clk(i_clk), .i_rst_n(i_rst_n),
      .i_pend_push(pend_push), .i_pend(pend),
      .i_wdata_rsp_valid(i_wdata_rsp_valid), .i_wdata_rsp_data(i_wdata_rsp_data),
      .i_host_rd_valid(i_host_rd_valid), .i_host_rd_addr(i_host_rd_addr),
      .o_host_rd_data(o_host_rd_data),
      .o_done_valid(done_valid), .o_done_tag(done_tag));

   // completion also returns the tag to the pool
   host_cmd_issue i_host_cmd_issue
     (.i_clk(i_clk), .i_rst_n(i_rst_n),
      .i_info_we(info_we), .i_info_tag(info_tag), .i_info(info),
      .i_done_valid(done_valid), .i_done_tag(done_tag),
      .o_host_cmd_valid(o_host_cmd_valid), .i_host_cmd_ready(i_host_cmd_ready),
      .o_host_cmd(o_host_cmd),
      .i_host_rsp_valid(i_host_rsp_valid), .i_host_rsp(i_host_rsp),
      .o_cpl_valid(o_cpl_valid), .o_cpl(o_cpl),
      .o_free_valid(free_valid), .o_free_tag(free_tag));

endmodule

//--- test/tb_dma_wr_model.svh
/* reference model state, expected-value queues and typed compare tasks
   for the DMA write engine testbench */
`ifndef TB_DMA_WR_MODEL_SVH
`define TB_DMA_WR_MODEL_SVH

typedef struct packed {int seq; dma_wr_pkg::wdata_req_t fr;} fetch_exp_t;
typedef struct packed {int due; int seq; dma_wr_pkg::beat_t beat;} data_due_t;
typedef struct packed {int seq; dma_wr_pkg::ltag_t tag;} host_job_t;
typedef struct packed {int due; dma_wr_pkg::data_t data;} rd_exp_t;
typedef struct packed {int due; dma_wr_pkg::ltag_t tag; dma_wr_pkg::cpl_t cpl;} cpl_exp_t;

// accepted requests in order, index is the request sequence
dma_wr_pkg::wr_req_t              req_log [$];
// delivered beat data, key is sequence * MAX_BEATS + beat
dma_wr_pkg::data_t                beat_data [int];
fetch_exp_t                       fetch_exp [$];
data_due_t                        data_due [$];
host_job_t                        host_q [$];
rd_exp_t                          rd_exp [$];
cpl_exp_t                         cpl_exp [$];
// set while a command with this tag waits for its completion
logic [0:dma_wr_pkg::NUM_LTAGS-1] tag_busy;
int                               n_checks;
int                               n_errors;
string                            test_name;

// size rounded up to whole 32-byte beats
function automatic int beats_of(input dma_wr_pkg::size_t size);
   return (int'(size) + dma_wr_pkg::BEAT_BYTES - 1) / dma_wr_pkg::BEAT_BYTES;
endfunction

task automatic flag_error(input string what);
   n_errors++;
   $display("ERROR %s: %s", test_name, what);
endtask

task automatic check_fetch(input dma_wr_pkg::wdata_req_t exp,
                           input dma_wr_pkg::wdata_req_t act);
   n_checks++;
   if (act !== exp)
   begin
      n_errors++;
      $display("MISMATCH %s fetch: expected etag %0d beat %0d, actual etag %0d beat %0d",
               test_name, exp.etag, exp.beat, act.etag, act.beat);
   end
endtask

task automatic check_cmd(input dma_wr_pkg::host_cmd_t exp,
                         input dma_wr_pkg::host_cmd_t act);
   n_checks++;
   if (act !== exp)
   begin
      n_errors++;
      $display("MISMATCH %s cmd: expected tag %0d ea %h size %0d, actual %0d %h %0d",
               test_name, exp.tag, exp.ea, exp.size, act.tag, act.ea, act.size);
   end
endtask

task automatic check_rd_data(input dma_wr_pkg::data_t exp, input dma_wr_pkg::data_t act);
   n_checks++;
   if (act !== exp)
   begin
      n_errors++;
      $display("MISMATCH %s host read: expected %h, actual %h", test_name, exp, act);
   end
endtask

task automatic check_cpl(input dma_wr_pkg::cpl_t exp, input dma_wr_pkg::cpl_t act);
   n_checks++;
   if (act !== exp)
   begin
      n_errors++;
      $display("MISMATCH %s completion: expected etag %0d rc %h, actual etag %0d rc %h",
               test_name, exp.etag, exp.rc, act.etag, act.rc);
   end
endtask

`endif

//--- test/tb_dma_wr.sv
`timescale 1ns/100ps
/* DMA write engine testbench: clock, reset, random request traffic,
   data and host responders, timeout and summary */
module tb_dma_wr;

   localparam int NUM_TESTS     = 3;
   localparam int REQS_PER_TEST = 60;
   // slow host test needs about 45 cycles per request
   localparam int CYC_PER_REQ   = 64;
   localparam int CYCLE_LIMIT   = NUM_TESTS * REQS_PER_TEST * CYC_PER_REQ + 1000;

   logic                   clk;
   logic                   rst_n;
   logic                   req_valid;
   logic                   req_ready;
   dma_wr_pkg::wr_req_t    req;
   logic                   wdata_req_valid;
   dma_wr_pkg::wdata_req_t wdata_req;
   logic                   wdata_rsp_valid;
   dma_wr_pkg::data_t      wdata_rsp_data;
   logic                   host_cmd_valid;
   logic                   host_cmd_ready;
   dma_wr_pkg::host_cmd_t  host_cmd;
   logic                   host_rd_valid;
   dma_wr_pkg::host_addr_t host_rd_addr;
   dma_wr_pkg::data_t      host_rd_data;
   logic                   host_rsp_valid;
   dma_wr_pkg::host_rsp_t  host_rsp;
   logic                   cpl_valid;
   dma_wr_pkg::cpl_t       cpl;

   integer                 seed;

   `include "tb_dma_wr_model.svh"

   int                     cycle;
   int                     wd_cycles;
   // knobs of the running test
   int                     dly_min;
   int                     dly_max;
   int                     rdy_pct;
   int                     gap_max;
   int                     issued;
   int                     completed;
   int                     inflight;
   int                     peak;
   int                     gap_cnt;
   logic                   req_taken;
   int                     last_due;
   int                     cmd_next;
   logic                   stall_pending;
   dma_wr_pkg::host_cmd_t  stall_cmd;
   logic                   hr_active;
   host_job_t              hr_job;
   int                     hr_beat;
   int                     hr_nbeats;
   int                     hr_wait;
   logic                   wait_ready;
   int                     wait_cnt;

   dma_wr_top i_dut
     (.i_clk(clk), .i_rst_n(rst_n),
      .i_req_valid(req_valid), .o_req_ready(req_ready), .i_req(req),
      .o_wdata_req_valid(wdata_req_valid), .o_wdata_req(wdata_req),
      .i_wdata_rsp_valid(wdata_rsp_valid), .i_wdata_rsp_data(wdata_rsp_data),
      .o_host_cmd_valid(host_cmd_valid), .i_host_cmd_ready(host_cmd_ready),
      .o_host_cmd(host_cmd),
      .i_host_rd_valid(host_rd_valid), .i_host_rd_addr(host_rd_addr),
      .o_host_rd_data(host_rd_data),
      .i_host_rsp_valid(host_rsp_valid), .i_host_rsp(host_rsp),
      .o_cpl_valid(cpl_valid), .o_cpl(cpl));

   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   function automatic int rand_int(input int lo, input int hi);
      return lo + int'({$random(seed)} % (hi - lo + 1));
   endfunction

   function automatic dma_wr_pkg::data_t rand_data();
      dma_wr_pkg::data_t d;
      for (int i = 0; i < dma_wr_pkg::DATA_W / 32; i++)
      begin
         d[i*32 +: 32] = $random(seed);
      end
      return d;
   endfunction

   // read data and completions due in this cycle
   task automatic check_outputs();
      rd_exp_t  re;
      cpl_exp_t ce;
      if (rd_exp.size() > 0 && rd_exp[0].due == cycle)
      begin
         re = rd_exp.pop_front();
         check_rd_data(re.data, host_rd_data);
      end
      if (cpl_exp.size() > 0 && cpl_exp[0].due == cycle)
      begin
         ce = cpl_exp.pop_front();
         if (!cpl_valid)
         begin
            flag_error("no completion two cycles after the host response");
         end
         else
         begin
            check_cpl(ce.cpl, cpl);
         end
         tag_busy[ce.tag] = 1'b0;
         if (inflight == dma_wr_pkg::NUM_LTAGS)
         begin
            wait_ready = 1'b1;
            wait_cnt   = 0;
         end
         inflight--;
         completed++;
      end
      else if (cpl_valid)
      begin
         flag_error("completion without a pending host response");
      end
   endtask

   task automatic serve_cmd();
      dma_wr_pkg::host_cmd_t exp;
      if (stall_pending)
      begin
         if (!host_cmd_valid)
         begin
            flag_error("host command dropped while stalled");
         end
         else
         begin
            check_cmd(stall_cmd, host_cmd);
         end
      end
      host_cmd_ready = (rand_int(0, 99) < rdy_pct);
      stall_pending  = host_cmd_valid && !host_cmd_ready;
      stall_cmd      = host_cmd;
      if (host_cmd_valid && host_cmd_ready)
      begin
         if (cmd_next >= req_log.size())
         begin
            flag_error("host command without an accepted request");
         end
         else
         begin
            if (tag_busy[host_cmd.tag])
            begin
               flag_error("host command uses a tag that is still outstanding");
            end
            exp = '{tag: host_cmd.tag, ea: req_log[cmd_next].ea,
                    size: req_log[cmd_next].size};
            check_cmd(exp, host_cmd);
            tag_busy[host_cmd.tag] = 1'b1;
            host_q.push_back('{seq: cmd_next, tag: host_cmd.tag});
            cmd_next++;
         end
      end
   endtask

   // host reads every beat of a command, then responds
   task automatic serve_host();
      rd_exp_t  re;
      cpl_exp_t ce;
      host_rd_valid  = 1'b0;
      host_rsp_valid = 1'b0;
      if (!hr_active && host_q.size() > 0)
      begin
         hr_job    = host_q.pop_front();
         hr_active = 1'b1;
         hr_beat   = 0;
         hr_nbeats = beats_of(req_log[hr_job.seq].size);
         hr_wait   = rand_int(dly_min, dly_max);
      end
      if (hr_active)
      begin
         if (hr_beat < hr_nbeats)
         begin
            host_rd_valid = 1'b1;
            host_rd_addr  = '{ltag: hr_job.tag, beat: dma_wr_pkg::beat_t'(hr_beat)};
            re.due  = cycle + 2;
            re.data = beat_data[hr_job.seq * dma_wr_pkg::MAX_BEATS + hr_beat];
            rd_exp.push_back(re);
            hr_beat++;
         end
         else if (hr_wait > 0)
         begin
            hr_wait--;
         end
         else
         begin
            host_rsp_valid = 1'b1;
            host_rsp       = '{tag: hr_job.tag, rc: dma_wr_pkg::rc_t'(rand_int(0, 255))};
            ce.due  = cycle + 2;
            ce.tag  = hr_job.tag;
            ce.cpl  = '{etag: req_log[hr_job.seq].etag, rc: host_rsp.rc};
            cpl_exp.push_back(ce);
            hr_active = 1'b0;
         end
      end
   endtask

   // data returns in fetch order after 1 to 4 cycles
   task automatic serve_fetch();
      fetch_exp_t fe;
      data_due_t  dd;
      wdata_rsp_valid = 1'b0;
      if (data_due.size() > 0 && data_due[0].due == cycle)
      begin
         dd = data_due.pop_front();
         wdata_rsp_data  = rand_data();
         wdata_rsp_valid = 1'b1;
         beat_data[dd.seq * dma_wr_pkg::MAX_BEATS + int'(dd.beat)] = wdata_rsp_data;
      end
      if (wdata_req_valid)
      begin
         if (fetch_exp.size() == 0)
         begin
            flag_error("data fetch with no request beat outstanding");
         end
         else
         begin
            fe = fetch_exp.pop_front();
            check_fetch(fe.fr, wdata_req);
            dd.due  = cycle + rand_int(1, 4);
            dd.due  = (dd.due <= last_due) ? last_due + 1 : dd.due;
            dd.seq  = fe.seq;
            dd.beat = fe.fr.beat;
            last_due = dd.due;
            data_due.push_back(dd);
         end
      end
   endtask

   task automatic accept_request();
      fetch_exp_t fe;
      fe.seq = req_log.size();
      req_log.push_back(req);
      for (int b = 0; b < beats_of(req.size); b++)
      begin
         fe.fr = '{etag: req.etag, beat: dma_wr_pkg::beat_t'(b)};
         fetch_exp.push_back(fe);
      end
      issued++;
      inflight++;
      peak = (inflight > peak) ? inflight : peak;
      if (inflight > dma_wr_pkg::NUM_LTAGS)
      begin
         flag_error("more than 16 requests accepted without completion");
      end
      req_taken = 1'b1;
   endtask

   task automatic drive_request();
      if (req_taken)
      begin
         req_valid = 1'b0;
         req_taken = 1'b0;
         gap_cnt   = rand_int(0, gap_max);
      end
      if (!req_valid && issued < REQS_PER_TEST)
      begin
         if (gap_cnt > 0)
         begin
            gap_cnt--;
         end
         else
         begin
            req.etag  = dma_wr_pkg::etag_t'(rand_int(0, 7));
            req.ea    = {$random(seed), $random(seed)};
            req.size  = dma_wr_pkg::size_t'(rand_int(1, 128));
            req_valid = 1'b1;
         end
      end
      if (inflight == dma_wr_pkg::NUM_LTAGS && req_ready)
      begin
         flag_error("request ready high with all 16 local tags outstanding");
      end
      // a freed tag must reopen intake within one unroll
      if (wait_ready)
      begin
         wait_cnt++;
         if (req_ready)
         begin
            wait_ready = 1'b0;
         end
         else if (wait_cnt > dma_wr_pkg::MAX_BEATS + 2)
         begin
            flag_error("request ready did not rise after a completion freed a tag");
            wait_ready = 1'b0;
         end
      end
      if (req_valid && req_ready)
      begin
         accept_request();
      end
   endtask

   task automatic step_cycle();
      cycle++;
      check_outputs();
      serve_cmd();
      serve_host();
      serve_fetch();
      drive_request();
   endtask

   task automatic run_test(input string name, input int d_min, input int d_max,
                           input int rdy, input int gap);
      int err_start;
      test_name = name;
      dly_min   = d_min;
      dly_max   = d_max;
      rdy_pct   = rdy;
      gap_max   = gap;
      err_start = n_errors;
      issued    = 0;
      completed = 0;
      peak      = 0;
      gap_cnt   = 0;
      while (completed < REQS_PER_TEST)
      begin
         @(negedge clk);
         step_cycle();
      end
      $display("test %s done: %0d requests, peak %0d tags outstanding, %0d errors",
               name, REQS_PER_TEST, peak, n_errors - err_start);
   endtask

   initial
   begin
      wd_cycles = 0;
      while (wd_cycles < CYCLE_LIMIT)
      begin
         @(posedge clk);
         wd_cycles++;
      end
      $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("*** FAILED ***");
      $finish;
   end

   initial
   begin
      seed            = 32'hd499_a283;
      rst_n           = 1'b0;
      req_valid       = 1'b0;
      req             = '0;
      wdata_rsp_valid = 1'b0;
      wdata_rsp_data  = '0;
      host_cmd_ready  = 1'b0;
      host_rd_valid   = 1'b0;
      host_rd_addr    = '0;
      host_rsp_valid  = 1'b0;
      host_rsp        = '0;
      tag_busy        = '0;
      n_checks        = 0;
      n_errors        = 0;
      cycle           = 0;
      inflight        = 0;
      cmd_next        = 0;
      last_due        = 0;
      req_taken       = 1'b0;
      stall_pending   = 1'b0;
      hr_active       = 1'b0;
      wait_ready      = 1'b0;
      test_name       = "reset";
      repeat (10) @(posedge clk);
      @(negedge clk);
      if (req_ready || wdata_req_valid || host_cmd_valid || cpl_valid)
      begin
         flag_error("handshake output active during reset");
      end
      rst_n = 1'b1;
      run_test("mixed", 0, 7, 75, 3);
      run_test("tag_full", 24, 40, 100, 0);
      // the full-pool checks only bite once all tags are out
      if (peak != dma_wr_pkg::NUM_LTAGS)
      begin
         flag_error("tag pool never reached 16 outstanding tags");
      end
      run_test("cmd_stall", 0, 3, 20, 1);
      test_name = "drain";
      repeat (8)
      begin
         @(negedge clk);
         step_cycle();
      end
      if (fetch_exp.size() != 0 || data_due.size() != 0)
      begin
         flag_error("data fetches still outstanding at the end");
      end
      if (cmd_next != req_log.size() || host_q.size() != 0)
      begin
         flag_error("host commands missing or unserved at the end");
      end
      $display("summary: %0d tests, %0d requests, %0d checks, %0d errors",
               NUM_TESTS, req_log.size(), n_checks, n_errors);
      if (n_errors == 0)
      begin
         $display("*** PASSED ***");
      end
      else
      begin
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule

//--- build.f
+incdir+test
rtl/dma_wr_pkg.sv
rtl/tag_pool.sv
rtl/beat_unroll.sv
rtl/wdata_buffer.sv
rtl/host_cmd_issue.sv
rtl/dma_wr_top.sv
test/tb_dma_wr.sv

//--- Makefile
# Verilator build and run of the DMA write engine testbench

SIM  := obj_dir/Vtb_dma_wr
SRCS := $(shell grep -v '^+' build.f) test/tb_dma_wr_model.svh

.PHONY: run clean

run: $(SIM)
	$(SIM) | tee sim.log
	grep -qxF '*** PASSED ***' sim.log

$(SIM): build.f $(SRCS)
	verilator --binary --timing --assert -f build.f --top-module tb_dma_wr -o Vtb_dma_wr

clean:
	rm -rf obj_dir sim.log
